//--- arb_sizes_pkg.sv
// sizing constants of the eight-input round-robin arbiter tree
// every width used by the types and the RTL derives from these values

package arb_sizes_pkg;

  //////////////////////////////////////////////////////////////////////
  // arbiter dimensions
  //////////////////////////////////////////////////////////////////////

  // number of arbitrated inputs, kept at a power of two so the tree has no padding
  localparam int unsigned num_in = 8;

  // width of one payload word
  localparam int unsigned data_width = 32;

  // bits needed to name one input
  localparam int unsigned idx_width = $clog2(num_in);

  // depth of the arbitration tree, one level per index bit
  localparam int unsigned num_levels = idx_width;

endpackage

//--- arb_types_pkg.sv
// vector types shared by the arbiter blocks
// each width that carries a meaning gets its own name

package arb_types_pkg;

  //////////////////////////////////////////////////////////////////////
  // request, index and payload types
  //////////////////////////////////////////////////////////////////////

  // one request or grant bit per input
  typedef logic [arb_sizes_pkg::num_in-1:0] req_vec_t;

  // index of one input, also used for the round-robin priority
  typedef logic [arb_sizes_pkg::idx_width-1:0] idx_t;

  // a single payload word
  typedef logic [arb_sizes_pkg::data_width-1:0] data_t;

  // all input payloads side by side, input 0 in the lowest slice
  typedef logic [arb_sizes_pkg::num_in*arb_sizes_pkg::data_width-1:0] data_vec_t;

endpackage

//--- trailing_zero_count.sv
// trailing-zero counter for a request mask
// returns the position of the lowest set bit and flags an empty mask

`timescale 1ns/1ps

module trailing_zero_count (
  input  arb_types_pkg::req_vec_t mask_i,
  output arb_types_pkg::idx_t     idx_o,
  output logic                    empty_o
);

  // scan from bit 0 upward and keep the first hit
  // an empty mask leaves the index at zero
  always_comb begin : p_scan
    idx_o   = '0;
    empty_o = 1'b1;
    for (int i = 0; i < $bits(arb_types_pkg::req_vec_t); i++) begin
      // once a bit has been found the higher ones no longer matter
      if (mask_i[i] && empty_o) begin
        idx_o   = arb_types_pkg::idx_t'(i);
        empty_o = 1'b0;
      end
    end
  end

endmodule

//--- rr_prio_ctrl.sv
// round-robin priority and lock-in control for the arbiter tree
// holds the priority index, the lock flag and the stored request mask

`timescale 1ns/1ps

module rr_prio_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  input  arb_types_pkg::req_vec_t req_i,
  input  logic                    req_o,
  input  logic                    gnt_i,
  output arb_types_pkg::req_vec_t eff_req_o,
  output arb_types_pkg::idx_t     prio_o
);

  // state registers
  logic                    lock_q;
  arb_types_pkg::req_vec_t req_q;
  arb_types_pkg::idx_t     prio_q;

  // next-state signals
  logic                    lock_d;
  logic                    transfer;
  arb_types_pkg::idx_t     prio_d;
  arb_types_pkg::idx_t     next_prio;

  // fair priority search
  arb_types_pkg::req_vec_t upper_mask;
  arb_types_pkg::req_vec_t lower_mask;
  arb_types_pkg::idx_t     upper_idx;
  arb_types_pkg::idx_t     lower_idx;
  logic                    upper_empty;
  logic                    lower_empty;

  //////////////////////////////////////////////////////////////////////
  // lock-in
  //////////////////////////////////////////////////////////////////////

  // the root request and the downstream grant meet here and only here
  assign transfer = req_o & gnt_i;

  // a pending request without a grant freezes the decision at the next edge
  assign lock_d = req_o & ~gnt_i;

  // while locked the tree keeps seeing the mask that won, new requests wait
  assign eff_req_o = lock_q ? req_q : req_i;
  assign prio_o    = prio_q;

  //////////////////////////////////////////////////////////////////////
  // fair priority update
  //////////////////////////////////////////////////////////////////////

  // split the effective requests around the current priority
  for (genvar i = 0; i < arb_sizes_pkg::num_in; i++) begin : gen_mask
    assign upper_mask[i] = (arb_types_pkg::idx_t'(i) >  prio_q) ? eff_req_o[i] : 1'b0;
    assign lower_mask[i] = (arb_types_pkg::idx_t'(i) <= prio_q) ? eff_req_o[i] : 1'b0;
  end

  // first requester above the current priority
  trailing_zero_count u_tzc_upper (
    .mask_i  (upper_mask),
    .idx_o   (upper_idx),
    .empty_o (upper_empty)
  );

  // first requester at or below it, used when the search wraps around
  trailing_zero_count u_tzc_lower (
    .mask_i  (lower_mask),
    .idx_o   (lower_idx),
    .empty_o (lower_empty)
  );

  // with no requester at all the priority simply stays where it is
  assign next_prio = !upper_empty ? upper_idx :
                     !lower_empty ? lower_idx : prio_q;

  // the priority only moves after something was actually handed over
  assign prio_d = transfer ? next_prio : prio_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      lock_q <= 1'b0;
      req_q  <= '0;
      prio_q <= '0;
    end else if (flush_i) begin
      lock_q <= 1'b0;
      req_q  <= '0;
      prio_q <= '0;
    end else begin
      lock_q <= lock_d;
      req_q  <= eff_req_o;
      prio_q <= prio_d;
    end
  end

  // a held decision with no grant keeps both the priority and the request view
  a_lock_stable : assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    lock_q && !gnt_i |=> $stable(prio_q) && $stable(eff_req_o))
    else $error("rr_prio_ctrl: locked decision changed without a grant");

  // requesters must keep every unserved request up while the arbiter is locked
  a_lock_req : assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    lock_q |-> (req_q & req_i) == req_q)
    else $error("rr_prio_ctrl: locked request dropped before it was served");

endmodule

//--- arb_tree.sv
// combinational round-robin arbitration tree
// reduces requests toward the root, muxes payload and index, and routes the grant back

`timescale 1ns/1ps

module arb_tree (
  input  arb_types_pkg::req_vec_t  req_i,
  input  arb_types_pkg::idx_t      prio_i,
  input  arb_types_pkg::data_vec_t data_i,
  input  logic                     gnt_i,
  output logic                     req_o,
  output arb_types_pkg::data_t     data_o,
  output arb_types_pkg::idx_t      idx_o,
  output arb_types_pkg::req_vec_t  gnt_o
);

  // level 0 is the root, the last level reads straight from the inputs
  for (genvar lvl = 0; lvl < arb_sizes_pkg::num_levels; lvl++) begin : gen_levels
    logic [2**lvl-1:0]    node_req;
    logic [2**lvl-1:0]    node_sel;
    logic [2**lvl-1:0]    node_gnt;
    arb_types_pkg::idx_t  node_idx  [2**lvl];
    arb_types_pkg::data_t node_data [2**lvl];

    for (genvar n = 0; n < 2**lvl; n++) begin : gen_nodes
      logic                 left_req;
      logic                 right_req;
      arb_types_pkg::idx_t  left_idx;
      arb_types_pkg::idx_t  right_idx;
      arb_types_pkg::data_t left_data;
      arb_types_pkg::data_t right_data;

      ////////////////////////////////////////////////////////////////////
      // children of this node
      ////////////////////////////////////////////////////////////////////
      if (lvl == arb_sizes_pkg::num_levels - 1) begin : gen_leaf
        // leaf pairs carry no index bits yet
        assign left_req   = req_i[2*n];
        assign right_req  = req_i[2*n+1];
        assign left_idx   = '0;
        assign right_idx  = '0;
        assign left_data  = data_i[2*n*arb_sizes_pkg::data_width +: arb_sizes_pkg::data_width];
        assign right_data = data_i[(2*n+1)*arb_sizes_pkg::data_width +:
                                   arb_sizes_pkg::data_width];

        // a leaf is granted only if it asked and the node picked its side
        assign gnt_o[2*n]   = node_gnt[n] & left_req  & ~node_sel[n];
        assign gnt_o[2*n+1] = node_gnt[n] & right_req &  node_sel[n];
      end else begin : gen_inner
        assign left_req   = gen_levels[lvl+1].node_req[2*n];
        assign right_req  = gen_levels[lvl+1].node_req[2*n+1];
        assign left_idx   = gen_levels[lvl+1].node_idx[2*n];
        assign right_idx  = gen_levels[lvl+1].node_idx[2*n+1];
        assign left_data  = gen_levels[lvl+1].node_data[2*n];
        assign right_data = gen_levels[lvl+1].node_data[2*n+1];
      end

      // grant arriving from above, split by the parent select
      if (lvl == 0) begin : gen_root_gnt
        assign node_gnt[n] = gnt_i;
      end else if (n % 2 == 0) begin : gen_left_gnt
        assign node_gnt[n] = gen_levels[lvl-1].node_gnt[n/2] & ~gen_levels[lvl-1].node_sel[n/2];
      end else begin : gen_right_gnt
        assign node_gnt[n] = gen_levels[lvl-1].node_gnt[n/2] & gen_levels[lvl-1].node_sel[n/2];
      end

      ////////////////////////////////////////////////////////////////////
      // node decision
      ////////////////////////////////////////////////////////////////////

      // right wins when left is idle, or when both ask and this level's priority bit is set
      assign node_sel[n] = ~left_req | (right_req & prio_i[arb_sizes_pkg::num_levels-1-lvl]);
      assign node_req[n] = left_req | right_req;

      // this level contributes one index bit on top of the winning child's bits
      assign node_idx[n] = (node_sel[n] ? right_idx : left_idx) |
                           (arb_types_pkg::idx_t'(node_sel[n]) <<
                            (arb_sizes_pkg::num_levels-1-lvl));
      assign node_data[n] = node_sel[n] ? right_data : left_data;
    end
  end

  // the final decision sits at the root
  assign req_o  = gen_levels[0].node_req[0];
  assign data_o = gen_levels[0].node_data[0];
  assign idx_o  = gen_levels[0].node_idx[0];

  // checked once the tree has settled, since inputs may change together
  always_comb begin : p_check
    assert final ($onehot0(gnt_o))
      else $error("arb_tree: more than one input granted");
    assert final (!(|gnt_o) || gnt_i)
      else $error("arb_tree: input granted without a downstream grant");
    assert final (!(req_o && gnt_i) || gnt_o[idx_o])
      else $error("arb_tree: granted input differs from idx_o");
    assert final (req_o == (|req_i))
      else $error("arb_tree: root request does not match the inputs");
  end

endmodule

//--- rr_arb_top.sv
// eight-input round-robin arbiter with lock-in and flush
// the priority block steers the combinational tree beside it

`timescale 1ns/1ps

module rr_arb_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     flush_i,
  input  arb_types_pkg::req_vec_t  req_i,
  input  arb_types_pkg::data_vec_t data_i,
  input  logic                     gnt_i,
  output arb_types_pkg::req_vec_t  gnt_o,
  output logic                     req_o,
  output arb_types_pkg::data_t     data_o,
  output arb_types_pkg::idx_t      idx_o
);

  // requests as the tree sees them, and the priority that orders them
  arb_types_pkg::req_vec_t eff_req;
  arb_types_pkg::idx_t     prio;

  rr_prio_ctrl u_prio_ctrl (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .flush_i   (flush_i),
    .req_i     (req_i),
    .req_o     (req_o),
    .gnt_i     (gnt_i),
    .eff_req_o (eff_req),
    .prio_o    (prio)
  );

  arb_tree u_tree (
    .req_i  (eff_req),
    .prio_i (prio),
    .data_i (data_i),
    .gnt_i  (gnt_i),
    .req_o  (req_o),
    .data_o (data_o),
    .idx_o  (idx_o),
    .gnt_o  (gnt_o)
  );

  // a request left waiting keeps the same winner in the next cycle
  a_lock_idx : assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
    req_o && !gnt_i |=> idx_o == $past(idx_o))
    else $error("rr_arb_top: winner changed while waiting for a grant");

  // the forwarded payload always comes from the input named by idx_o
  a_data_src : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_o |-> data_o == data_i[idx_o*arb_sizes_pkg::data_width +: arb_sizes_pkg::data_width])
    else $error("rr_arb_top: payload does not match idx_o");

endmodule

//--- rr_arb_tb.sv
// testbench for the eight-input round-robin arbiter
// a reference priority model runs beside the DUT and assertions compare the two

`timescale 1ns/1ps

module rr_arb_tb;

  localparam int reset_cycles   = 4;
  localparam int timeout_cycles = 40;
  localparam int random_cycles  = 300;

  logic                     clk;
  logic                     rst_n;
  logic                     flush;
  arb_types_pkg::req_vec_t  req;
  arb_types_pkg::data_vec_t data;
  logic                     gnt_down;
  arb_types_pkg::req_vec_t  gnt_up;
  logic                     req_out;
  arb_types_pkg::data_t     data_out;
  arb_types_pkg::idx_t      idx_out;

  int seed;
  int assert_errs;
  int check_errs;
  int timeouts;

  // reference model state and the responses it predicts
  arb_types_pkg::idx_t     model_prio;
  logic                    model_lock;
  arb_types_pkg::req_vec_t model_req_q;
  arb_types_pkg::req_vec_t model_eff;
  logic                    exp_any;
  arb_types_pkg::idx_t     exp_idx;
  arb_types_pkg::req_vec_t exp_gnt;
  arb_types_pkg::data_t    exp_data;

  rr_arb_top DUT (
    .clk_i   (clk),
    .rst_ni  (rst_n),
    .flush_i (flush),
    .req_i   (req),
    .data_i  (data),
    .gnt_i   (gnt_down),
    .gnt_o   (gnt_up),
    .req_o   (req_out),
    .data_o  (data_out),
    .idx_o   (idx_out)
  );

  initial begin : p_clock
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // walk down from the root, halving the window at every level
  function automatic arb_types_pkg::idx_t tree_winner(arb_types_pkg::req_vec_t r,
                                                      arb_types_pkg::idx_t p);
    int   lo;
    int   half;
    logic left_any;
    logic right_any;
    lo   = 0;
    half = arb_sizes_pkg::num_in / 2;
    for (int lvl = 0; lvl < arb_sizes_pkg::num_levels; lvl++) begin
      left_any  = 1'b0;
      right_any = 1'b0;
      for (int i = 0; i < half; i++) begin
        left_any  = left_any | r[lo+i];
        right_any = right_any | r[lo+half+i];
      end
      // the right half takes over when the left is idle or the priority bit points there
      if (!left_any || (right_any && p[arb_sizes_pkg::num_levels-1-lvl])) lo = lo + half;
      half = half / 2;
    end
    return arb_types_pkg::idx_t'(lo);
  endfunction

  // lowest requester above the priority, else the lowest one at or below it
  function automatic arb_types_pkg::idx_t next_priority(arb_types_pkg::req_vec_t r,
                                                        arb_types_pkg::idx_t p);
    arb_types_pkg::idx_t result;
    logic                found;
    result = p;
    found  = 1'b0;
    for (int i = int'(p) + 1; i < arb_sizes_pkg::num_in; i++) begin
      if (r[i] && !found) begin
        result = arb_types_pkg::idx_t'(i);
        found  = 1'b1;
      end
    end
    for (int i = 0; i <= int'(p); i++) begin
      if (r[i] && !found) begin
        result = arb_types_pkg::idx_t'(i);
        found  = 1'b1;
      end
    end
    return result;
  endfunction

  assign model_eff = model_lock ? model_req_q : req;
  assign exp_any   = |model_eff;
  assign exp_idx   = tree_winner(model_eff, model_prio);
  assign exp_gnt   = (exp_any && gnt_down) ? arb_types_pkg::req_vec_t'(1) << exp_idx : '0;
  assign exp_data  = data[exp_idx*arb_sizes_pkg::data_width +: arb_sizes_pkg::data_width];

  // follows the port signals only, one update per rising edge
  always @(posedge clk or negedge rst_n) begin : p_model
    if (!rst_n || flush) begin
      model_prio  <= '0;
      model_lock  <= 1'b0;
      model_req_q <= '0;
    end else begin
      if (exp_any && gnt_down) model_prio <= next_priority(model_eff, model_prio);
      model_lock  <= exp_any && !gnt_down;
      model_req_q <= model_eff;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  a_root_req : assert property (@(posedge clk) disable iff (!rst_n) req_out == exp_any)
    else begin assert_errs++; $display("mismatch at %0t: req_o differs from model", $time); end

  a_winner : assert property (@(posedge clk) disable iff (!rst_n) exp_any |-> idx_out == exp_idx)
    else begin assert_errs++; $display("mismatch at %0t: idx_o breaks the tree rule", $time); end

  // the input named by the priority always wins when it asks
  a_prio_first : assert property (@(posedge clk) disable iff (!rst_n)
    model_eff[model_prio] |-> req_out && idx_out == model_prio)
    else begin assert_errs++; $display("mismatch at %0t: priority input lost", $time); end

  a_grant : assert property (@(posedge clk) disable iff (!rst_n) gnt_up == exp_gnt)
    else begin assert_errs++; $display("mismatch at %0t: gnt_o differs from model", $time); end

  a_onehot : assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gnt_up))
    else begin assert_errs++; $display("mismatch at %0t: gnt_o not one-hot", $time); end

  // the top bits of every payload carry the number of the input it came from
  a_payload : assert property (@(posedge clk) disable iff (!rst_n)
    exp_any |-> data_out == exp_data &&
    data_out[arb_sizes_pkg::data_width-1 -: arb_sizes_pkg::idx_width] == exp_idx)
    else begin assert_errs++; $display("mismatch at %0t: data_o from wrong input", $time); end

  a_hold : assert property (@(posedge clk) disable iff (!rst_n || flush)
    req_out && !gnt_down |=> idx_out == $past(idx_out))
    else begin assert_errs++; $display("mismatch at %0t: idx_o moved while waiting", $time); end

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  task automatic new_payloads();
    logic [31:0] rnd;
    for (int k = 0; k < arb_sizes_pkg::num_in; k++) begin
      rnd = $random(seed);
      data[k*arb_sizes_pkg::data_width +: arb_sizes_pkg::data_width] =
        {arb_types_pkg::idx_t'(k), rnd[arb_sizes_pkg::data_width-arb_sizes_pkg::idx_width-1:0]};
    end
  endtask

  // inputs change on the falling edge, outputs are read once they have settled
  task automatic drive(arb_types_pkg::req_vec_t r, logic g, logic f, logic renew);
    @(negedge clk);
    req      = r;
    gnt_down = g;
    flush    = f;
    if (renew) new_payloads();
    #1;
  endtask

  task automatic next_cycle();
    @(negedge clk);
    #1;
  endtask

  task automatic expect_equal(logic [31:0] got, logic [31:0] exp, string what);
    if (got !== exp) begin
      check_errs++;
      $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // a transfer seen mid-cycle completes at the next rising edge
  task automatic wait_transfer(output arb_types_pkg::idx_t served);
    int   n;
    logic seen;
    n      = 0;
    seen   = 1'b0;
    served = '0;
    while (!seen && n < timeout_cycles) begin
      if (req_out && gnt_down) begin
        served = idx_out;
        seen   = 1'b1;
      end else begin
        next_cycle();
        n++;
      end
    end
    if (seen) begin
      next_cycle();
    end else begin
      timeouts++;
      $display("timeout: no transfer happened within %0d cycles at %0t", timeout_cycles, $time);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : p_main
    logic [31:0]             rnd;
    arb_types_pkg::req_vec_t r;
    arb_types_pkg::idx_t     served;
    arb_types_pkg::idx_t     held_idx;
    arb_types_pkg::data_t    held_data;
    seed        = 32'ha7d4;
    assert_errs = 0;
    check_errs  = 0;
    timeouts    = 0;
    rst_n       = 1'b0;
    flush       = 1'b0;
    req         = '0;
    gnt_down    = 1'b0;
    data        = '0;
    new_payloads();
    repeat (reset_cycles) @(negedge clk);
    rst_n = 1'b1;

    // from reset, two requesters take turns
    // the first transfer lifts the priority from 0 to input 2, which then wins once more
    drive(8'h24, 1'b1, 1'b0, 1'b1);
    for (int i = 0; i < 6; i++) begin
      wait_transfer(served);
      expect_equal(served, (i >= 2 && i % 2 == 0) ? 5 : 2, "alternating winner");
    end

    // one requester at a time, first without and then with a downstream grant
    for (int k = 0; k < arb_sizes_pkg::num_in; k++) begin
      drive(arb_types_pkg::req_vec_t'(1) << k, 1'b0, 1'b0, 1'b1);
      expect_equal(gnt_up, 0, "gnt_o without gnt_i");
      drive(arb_types_pkg::req_vec_t'(1) << k, 1'b1, 1'b0, 1'b0);
      expect_equal(idx_out, k, "single request idx_o");
      expect_equal(data_out, data[k*arb_sizes_pkg::data_width +: arb_sizes_pkg::data_width],
                   "single request data_o");
      expect_equal(gnt_up, 1 << k, "single request gnt_o");
    end

    // full load after a flush rotates through every input in order
    drive(8'h00, 1'b0, 1'b1, 1'b0);
    drive(8'hff, 1'b1, 1'b0, 1'b0);
    for (int i = 0; i < 2 * arb_sizes_pkg::num_in; i++) begin
      wait_transfer(served);
      expect_equal(served, i % arb_sizes_pkg::num_in, "rotation winner");
    end

    // new requests arriving during back-pressure must not steal the locked slot
    // the priority sits at input 1 here, so adding it would win if the lock failed
    drive(8'h10, 1'b0, 1'b0, 1'b1);
    held_idx  = idx_out;
    held_data = data_out;
    r         = 8'h10;
    for (int c = 0; c < 4; c++) begin
      r = (c == 3) ? 8'hff : r | (arb_types_pkg::req_vec_t'(1) << model_prio);
      drive(r, 1'b0, 1'b0, 1'b0);
      expect_equal(idx_out, held_idx, "locked idx_o");
      expect_equal(data_out, held_data, "locked data_o");
    end
    drive(8'hff, 1'b1, 1'b0, 1'b0);
    wait_transfer(served);
    expect_equal(served, held_idx, "locked transfer");

    // flush drops a held lock and brings the priority back to input 0
    drive(8'h90, 1'b0, 1'b0, 1'b0);
    drive(8'h90, 1'b0, 1'b1, 1'b0);
    drive(8'hff, 1'b1, 1'b0, 1'b0);
    expect_equal(model_prio, 0, "priority after flush");
    expect_equal(model_lock, 0, "lock after flush");
    wait_transfer(served);
    expect_equal(served, 0, "first transfer after flush");

    // random load, a pending request keeps its stored mask alive
    for (int c = 0; c < random_cycles; c++) begin
      rnd = $random(seed);
      r   = rnd[7:0];
      if (exp_any && !gnt_down) r = r | model_eff;
      drive(r, rnd[9:8] != 2'b00, 1'b0, 1'b1);
    end
    drive(8'h00, 1'b0, 1'b0, 1'b0);
    next_cycle();

    $display("errors: %0d assertion, %0d check, %0d timeout", assert_errs, check_errs, timeouts);
    if (assert_errs == 0 && check_errs == 0 && timeouts == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- rr_arb.f
arb_sizes_pkg.sv
arb_types_pkg.sv
trailing_zero_count.sv
rr_prio_ctrl.sv
arb_tree.sv
rr_arb_top.sv
rr_arb_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the round-robin arbiter testbench with Verilator
# the run passes only if the log holds the pass line

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f rr_arb.f --top-module rr_arb_tb -o rr_arb_sim > sim.log 2>&1 \
  && ./obj_dir/rr_arb_sim >> sim.log 2>&1

grep -qx "Done: no errors" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
